// File: files.f
design/sdCmdPkg.sv
design/crc7.sv
design/cmdIssuer.sv
design/cmdQueue.sv
design/sdCmdEngine.sv
design/sdCmdController.sv
tests/sdCardModel.sv
tests/sdCmdTb.sv

// File: run.sh
#!/bin/sh
# Build and run the SD command path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module sdCmdTb -f files.f -o sdSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sdSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// File: tests/sdCmdTb.sv
`timescale 1ns/1ps

module sdCmdTb;

    localparam int WaitLimit = 20000;

    logic               clk;
    logic               en;
    logic               cmdReq;
    logic               cmdAck;
    logic [5:0]         cmdIndex;
    logic [31:0]        cmdArg;
    logic               respReq;
    logic               respAck;
    sdCmdPkg::respFrame respFrame;
    logic               sdClk;
    logic               cmdOut;
    logic               cmdOutEn;
    logic               cmdIn;
    logic [1:0]         replyMode;
    logic [47:0]        replyFrame;
    logic [47:0]        captured;
    int                 frameCount;
    logic [31:0]        lfsr;
    sdCmdPkg::respFrame got [4];

    // Depth 1 on both queues so four commands fill everything
    sdCmdController #(
        .HalfPeriod (2),
        .CmdDepth   (1),
        .RespDepth  (1),
        .RespTimeout(64)
    ) i_sdCmdController (
        .clk      (clk),
        .en       (en),
        .cmdReq   (cmdReq),
        .cmdAck   (cmdAck),
        .cmdIndex (cmdIndex),
        .cmdArg   (cmdArg),
        .respReq  (respReq),
        .respAck  (respAck),
        .respFrame(respFrame),
        .sdClk    (sdClk),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn),
        .cmdIn    (cmdIn)
    );

    sdCardModel i_card (
        .sdClk     (sdClk),
        .cmdOut    (cmdOut),
        .cmdOutEn  (cmdOutEn),
        .cmdIn     (cmdIn),
        .replyMode (replyMode),
        .replyFrame(replyFrame),
        .captured  (captured),
        .frameCount(frameCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = !clk;
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randWord();
        logic [31:0] w;
        logic        fb;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            w    = {w[30:0], fb};
        end
        return w;
    endfunction

    // Reference CRC7 shifted MSB first
    function automatic logic [6:0] crcRef(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    // Card response with start and transmission bits low ahead of index and arg
    function automatic logic [47:0] buildReply(input logic [5:0] idx, input logic [31:0] arg);
        logic [39:0] body;
        body = {2'b00, idx, arg};
        return {body, crcRef(body), 1'b1};
    endfunction

    task automatic finishCmd();
        int n;
        n = 0;
        while (!cmdAck) begin
            @(negedge clk);
            n++;
            if (n > WaitLimit) stopRun("Timeout waiting for cmdAck to rise");
        end
        cmdReq = 1'b0;
        n = 0;
        while (cmdAck) begin
            @(negedge clk);
            n++;
            if (n > WaitLimit) stopRun("Timeout waiting for cmdAck to fall");
        end
    endtask

    task automatic sendCmd(input logic [5:0] idx, input logic [31:0] arg);
        @(negedge clk);
        cmdIndex = idx;
        cmdArg   = arg;
        cmdReq   = 1'b1;
        finishCmd();
    endtask

    task automatic getResult(output sdCmdPkg::respFrame r);
        int n;
        n = 0;
        while (!respReq) begin
            @(negedge clk);
            n++;
            if (n > WaitLimit) stopRun("Timeout waiting for a result");
        end
        r       = respFrame;
        respAck = 1'b1;
        n = 0;
        while (respReq) begin
            @(negedge clk);
            n++;
            if (n > WaitLimit) stopRun("Timeout waiting for respReq to fall");
        end
        respAck = 1'b0;
    endtask

    task automatic checkResult(input sdCmdPkg::respFrame r, input logic [5:0] idx,
                               input logic [31:0] arg, input sdCmdPkg::respStatus st);
        assert (r.index == idx && r.arg == arg && r.status == st) else
            stopRun($sformatf("ERR %0t: result %h/%h/%s, expected %h/%h/%s", $time,
                              r.index, r.arg, r.status.name(), idx, arg, st.name()));
    endtask

    // Frame as seen by the card
    task automatic checkCaptured(input logic [5:0] idx, input logic [31:0] arg);
        assert (captured[47:46] == 2'b01 && captured[45:40] == idx &&
                captured[39:8] == arg && captured[7:1] == crcRef({2'b01, idx, arg}) &&
                captured[0]) else
            stopRun($sformatf("ERR %0t: frame %h for CMD%0d arg %h", $time, captured, idx, arg));
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic testReset();
        @(negedge clk);
        assert (!respReq && !cmdAck && !sdClk && !cmdOutEn && cmdOut) else
            stopRun($sformatf("ERR %0t: idle outputs wrong after reset", $time));
    endtask

    task automatic testSingle(input logic [5:0] idx, input logic [1:0] mode,
                              input sdCmdPkg::respStatus st);
        sdCmdPkg::respFrame r;
        logic [31:0]        arg;
        logic [31:0]        cardArg;
        arg        = randWord();
        cardArg    = randWord();
        replyMode  = mode;
        replyFrame = buildReply(idx, cardArg);
        sendCmd(idx, arg);
        getResult(r);
        checkCaptured(idx, arg);
        // Received index and argument kept whenever the card answered
        if (st == sdCmdPkg::statOk || st == sdCmdPkg::statBadFrame) begin
            checkResult(r, idx, cardArg, st);
        end else begin
            checkResult(r, 6'd0, 32'd0, st);
        end
    endtask

    task automatic testBackPressure();
        logic [31:0] cardArg;
        int          base;
        cardArg    = randWord();
        replyMode  = 2'd1;
        replyFrame = buildReply(6'd8, cardArg);
        base       = frameCount;
        sendCmd(6'd8, randWord());
        sendCmd(6'd0, randWord());
        sendCmd(6'd17, randWord());
        @(negedge clk);
        cmdIndex = 6'd0;
        cmdArg   = randWord();
        cmdReq   = 1'b1;
        // Let the second command run to completion
        for (int n = 0; frameCount < base + 2; n++) begin
            @(negedge clk);
            if (n > WaitLimit) stopRun("Timeout waiting for the second frame");
        end
        repeat (1500) begin
            @(negedge clk);
            assert (!cmdAck) else
                stopRun($sformatf("ERR %0t: cmdAck rose with both queues full", $time));
        end
        assert (frameCount == base + 2) else
            stopRun($sformatf("ERR %0t: engine took a frame while stalled", $time));
        fork
            finishCmd();
            for (int k = 0; k < 4; k++) begin
                getResult(got[k]);
            end
        join
        checkResult(got[0], 6'd8, cardArg, sdCmdPkg::statOk);
        checkResult(got[1], 6'd0, 32'd0, sdCmdPkg::statNoResp);
        checkResult(got[2], 6'd8, cardArg, sdCmdPkg::statOk);
        checkResult(got[3], 6'd0, 32'd0, sdCmdPkg::statNoResp);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        lfsr       = 32'hb851;
        en         = 1'b0;
        cmdReq     = 1'b0;
        cmdIndex   = '0;
        cmdArg     = '0;
        respAck    = 1'b0;
        replyMode  = 2'd0;
        replyFrame = '1;
        repeat (8) @(negedge clk);
        en = 1'b1;

        testReset();
        testSingle(6'd0, 2'd1, sdCmdPkg::statNoResp);
        testSingle(6'd8, 2'd1, sdCmdPkg::statOk);
        testSingle(6'd55, 2'd2, sdCmdPkg::statBadFrame);
        testSingle(6'd41, 2'd0, sdCmdPkg::statTimeout);
        testBackPressure();

        $display("All tests passed");
        $finish;
    end

endmodule

// File: tests/sdCardModel.sv
`timescale 1ns/1ps

module sdCardModel (
    input  logic        sdClk,
    input  logic        cmdOut,
    input  logic        cmdOutEn,
    output logic        cmdIn,
    // Reply behavior set by the testbench
    input  logic [1:0]  replyMode,
    input  logic [47:0] replyFrame,
    // Last command frame seen on the line
    output logic [47:0] captured,
    output int          frameCount
);

    localparam logic [1:0] ModeSilent = 2'd0;
    localparam logic [1:0] ModeBadCrc = 2'd2;
    // Card cycles between stop bit and response start bit
    localparam int GapCycles = 2;

    logic [47:0] shiftReg;
    logic [47:0] reply;

    initial begin
        cmdIn      = 1'b1;
        captured   = '0;
        frameCount = 0;
    end

    always begin
        @(posedge sdClk);
        // Start bit seen while the host drives
        if (cmdOutEn && !cmdOut) begin
            shiftReg = '0;
            repeat (47) begin
                @(posedge sdClk);
                shiftReg = {shiftReg[46:0], cmdOut};
            end
            captured   = shiftReg;
            frameCount = frameCount + 1;
            // CMD0 never gets an answer from a card
            if (replyMode != ModeSilent && shiftReg[45:40] != 6'd0) begin
                reply = replyFrame;
                if (replyMode == ModeBadCrc) begin
                    reply[1] = !reply[1];
                end
                repeat (GapCycles) @(negedge sdClk);
                // Bits change on falling edges
                for (int i = 47; i >= 0; i--) begin
                    cmdIn <= reply[i];
                    @(negedge sdClk);
                end
                cmdIn <= 1'b1;
            end
        end
    end

endmodule

// File: design/sdCmdController.sv
`timescale 1ns/1ps

module sdCmdController #(
    parameter int HalfPeriod  = 2,
    parameter int CmdDepth    = 4,
    parameter int RespDepth   = 4,
    parameter int RespTimeout = 64
) (
    input  logic               clk,
    input  logic               en,
    // Host command port
    input  logic               cmdReq,
    output logic               cmdAck,
    input  logic [5:0]         cmdIndex,
    input  logic [31:0]        cmdArg,
    // Host result port
    output logic               respReq,
    input  logic               respAck,
    output sdCmdPkg::respFrame respFrame,
    // Card side
    output logic               sdClk,
    output logic               cmdOut,
    output logic               cmdOutEn,
    input  logic               cmdIn
);

    // Issuer to command queue
    logic               issReq;
    logic               issAck;
    sdCmdPkg::cmdFrame  issFrame;
    // Command queue to engine
    logic               engReq;
    logic               engAck;
    sdCmdPkg::cmdFrame  engFrame;
    // Engine to response queue
    logic               resReq;
    logic               resAck;
    sdCmdPkg::respFrame resFrame;

    cmdIssuer i_cmdIssuer (
        .clk     (clk),
        .en      (en),
        .cmdReq  (cmdReq),
        .cmdAck  (cmdAck),
        .cmdIndex(cmdIndex),
        .cmdArg  (cmdArg),
        .frameReq(issReq),
        .frameAck(issAck),
        .frame   (issFrame)
    );

    // ==============================
    // Command buffer
    // ==============================
    cmdQueue #(
        .PayloadType(sdCmdPkg::cmdFrame),
        .Depth      (CmdDepth)
    ) i_cmdQueue (
        .clk    (clk),
        .en     (en),
        .inReq  (issReq),
        .inAck  (issAck),
        .inData (issFrame),
        .outReq (engReq),
        .outAck (engAck),
        .outData(engFrame)
    );

    sdCmdEngine #(
        .HalfPeriod (HalfPeriod),
        .RespTimeout(RespTimeout)
    ) i_sdCmdEngine (
        .clk      (clk),
        .en       (en),
        .frameReq (engReq),
        .frameAck (engAck),
        .frame    (engFrame),
        .resultReq(resReq),
        .resultAck(resAck),
        .result   (resFrame),
        .sdClk    (sdClk),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn),
        .cmdIn    (cmdIn)
    );

    // ==============================
    // Result buffer
    // ==============================
    cmdQueue #(
        .PayloadType(sdCmdPkg::respFrame),
        .Depth      (RespDepth)
    ) i_respQueue (
        .clk    (clk),
        .en     (en),
        .inReq  (resReq),
        .inAck  (resAck),
        .inData (resFrame),
        .outReq (respReq),
        .outAck (respAck),
        .outData(respFrame)
    );

endmodule

// File: design/sdCmdEngine.sv
`timescale 1ns/1ps

module sdCmdEngine #(
    parameter int HalfPeriod  = 2,
    parameter int RespTimeout = 64
) (
    input  logic               clk,
    input  logic               en,
    // From command queue
    input  logic               frameReq,
    output logic               frameAck,
    input  sdCmdPkg::cmdFrame  frame,
    // To response queue
    output logic               resultReq,
    input  logic               resultAck,
    output sdCmdPkg::respFrame result,
    // Card side
    output logic               sdClk,
    output logic               cmdOut,
    output logic               cmdOutEn,
    input  logic               cmdIn
);

    // Start, transmission, index and argument
    localparam int BodyBits = sdCmdPkg::FrameBits - 8;
    localparam int DivBits  = $clog2(HalfPeriod + 2);
    localparam int WaitBits = $clog2(RespTimeout + 1);
    localparam int CntBits  = $clog2(sdCmdPkg::FrameBits + 1);

    typedef enum logic [2:0] {
        sIdle,
        sSendBody,
        sSendCrc,
        sWaitStart,
        sRecv,
        sCheck,
        sReport
    } enginePhase;

    enginePhase                     phase;
    logic [DivBits-1:0]             divCnt;
    logic [CntBits-1:0]             bitCnt;
    logic [WaitBits-1:0]            waitCnt;
    logic                           needResp;
    logic [BodyBits-1:0]            txShift;
    logic [sdCmdPkg::FrameBits-1:0] rxShift;
    logic [6:0]                     txCrc;
    logic [6:0]                     rxCrc;
    logic                           running;
    logic                           tick;
    logic                           riseTick;
    logic                           fallTick;
    logic                           take;
    logic                           bodyLast;
    logic                           crcLast;
    logic                           timedOut;
    logic                           txCrcEn;
    logic                           rxCrcEn;
    logic                           frameOk;

    // ==============================
    // Strobes
    // ==============================
    // Card clock only while a frame moves
    assign running  = phase inside {sSendBody, sSendCrc, sWaitStart, sRecv};
    assign tick     = running && (divCnt == DivBits'(HalfPeriod));
    assign riseTick = tick && !sdClk;
    assign fallTick = tick && sdClk;
    // Next command only once the previous result handshake is over
    assign take     = (phase == sIdle) && frameReq && !frameAck && !resultAck;
    assign bodyLast = fallTick && (phase == sSendBody) && (bitCnt == CntBits'(BodyBits - 1));
    // Seven CRC bits plus stop bit
    assign crcLast  = fallTick && (phase == sSendCrc) && (bitCnt == CntBits'(7));
    assign timedOut = fallTick && (phase == sWaitStart) && (waitCnt == WaitBits'(RespTimeout));
    assign txCrcEn  = riseTick && (phase == sSendBody);
    // Response bits 46 down to 8
    assign rxCrcEn  = riseTick && (phase == sRecv) && (bitCnt < CntBits'(BodyBits));
    // Start and transmission bits low, CRC match, stop bit high
    assign frameOk  = (rxShift[47:46] == 2'b00) && (rxCrc == rxShift[7:1]) && rxShift[0];

    crc7 i_txCrc (
        .clk  (clk),
        .en   (en),
        .clear(take),
        .shift(txCrcEn),
        .din  (cmdOut),
        .crc  (txCrc)
    );

    crc7 i_rxCrc (
        .clk  (clk),
        .en   (en),
        .clear(take),
        .shift(rxCrcEn),
        .din  (cmdIn),
        .crc  (rxCrc)
    );

    // ==============================
    // Phase FSM
    // ==============================
    always_ff @(posedge clk or negedge en) begin
        if (!en) begin
            phase     <= sIdle;
            divCnt    <= '0;
            bitCnt    <= '0;
            waitCnt   <= '0;
            needResp  <= 1'b0;
            frameAck  <= 1'b0;
            resultReq <= 1'b0;
            sdClk     <= 1'b0;
            cmdOut    <= 1'b1;
            cmdOutEn  <= 1'b0;
        end else begin
            // Half-period divider
            if (!running || tick) begin
                divCnt <= '0;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
            if (tick) begin
                sdClk <= !sdClk;
            end

            // Release frame ack after queue drops req
            if (frameAck && !frameReq) begin
                frameAck <= 1'b0;
            end

            case (phase)
                sIdle: if (take) begin
                    frameAck <= 1'b1;
                    needResp <= frame.needResp;
                    // Start bit goes out first
                    cmdOut   <= 1'b0;
                    cmdOutEn <= 1'b1;
                    bitCnt   <= '0;
                    waitCnt  <= '0;
                    phase    <= sSendBody;
                end
                // Bits change just after falling edges
                sSendBody: if (fallTick) begin
                    if (bodyLast) begin
                        cmdOut <= txCrc[6];
                        bitCnt <= '0;
                        phase  <= sSendCrc;
                    end else begin
                        cmdOut <= txShift[BodyBits-2];
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                sSendCrc: if (fallTick) begin
                    if (crcLast) begin
                        cmdOut   <= 1'b1;
                        cmdOutEn <= 1'b0;
                        if (needResp) begin
                            phase <= sWaitStart;
                        end else begin
                            resultReq <= 1'b1;
                            phase     <= sReport;
                        end
                    end else begin
                        cmdOut <= txShift[BodyBits-2];
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                // Look for start bit on each rising edge
                sWaitStart: begin
                    if (riseTick) begin
                        if (!cmdIn) begin
                            bitCnt <= CntBits'(1);
                            phase  <= sRecv;
                        end else begin
                            waitCnt <= waitCnt + 1'b1;
                        end
                    end else if (timedOut) begin
                        resultReq <= 1'b1;
                        phase     <= sReport;
                    end
                end
                // Leave on a falling edge so sdClk rests low
                sRecv: begin
                    if (riseTick) begin
                        bitCnt <= bitCnt + 1'b1;
                    end else if (fallTick && bitCnt == CntBits'(sdCmdPkg::FrameBits)) begin
                        phase <= sCheck;
                    end
                end
                sCheck: begin
                    resultReq <= 1'b1;
                    phase     <= sReport;
                end
                // Held here while the response queue is full
                sReport: if (resultAck) begin
                    resultReq <= 1'b0;
                    phase     <= sIdle;
                end
                default: phase <= sIdle;
            endcase
        end
    end

    // ==============================
    // Shift registers and result
    // ==============================
    always_ff @(posedge clk) begin
        if (take) begin
            txShift <= {2'b01, frame.index, frame.arg};
        end else if (bodyLast) begin
            txShift <= {txCrc, 1'b1, {(BodyBits - 8){1'b0}}};
        end else if (fallTick) begin
            txShift <= {txShift[BodyBits-2:0], 1'b0};
        end

        // Start bit included so the frame lines up at the end
        if (riseTick && (phase == sRecv || (phase == sWaitStart && !cmdIn))) begin
            rxShift <= {rxShift[sdCmdPkg::FrameBits-2:0], cmdIn};
        end

        if (phase == sCheck) begin
            result.index  <= rxShift[45:40];
            result.arg    <= rxShift[39:8];
            result.status <= frameOk ? sdCmdPkg::statOk : sdCmdPkg::statBadFrame;
        end else if (crcLast && !needResp) begin
            result <= '{index: '0, arg: '0, status: sdCmdPkg::statNoResp};
        end else if (timedOut) begin
            result <= '{index: '0, arg: '0, status: sdCmdPkg::statTimeout};
        end
    end

endmodule

// File: design/cmdQueue.sv
`timescale 1ns/1ps

module cmdQueue #(
    parameter type PayloadType = logic [7:0],
    parameter int  Depth       = 4
) (
    input  logic       clk,
    input  logic       en,
    // Write side
    input  logic       inReq,
    output logic       inAck,
    input  PayloadType inData,
    // Read side
    output logic       outReq,
    input  logic       outAck,
    output PayloadType outData
);

    localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntBits = $clog2(Depth + 1);

    PayloadType         mem [Depth];
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [CntBits-1:0] fill;
    logic               push;
    logic               pop;

    // Pointer wrap for any depth
    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // New request with room left
    assign push = inReq && !inAck && (fill != CntBits'(Depth));
    // Consumer took the head entry
    assign pop  = outReq && outAck;

    // Head entry held until pop
    assign outData = mem[rdPtr];

    // ==============================
    // Both four-phase sides
    // ==============================
    always_ff @(posedge clk or negedge en) begin
        if (!en) begin
            inAck  <= 1'b0;
            outReq <= 1'b0;
            wrPtr  <= '0;
            rdPtr  <= '0;
            fill   <= '0;
        end else begin
            // Write side
            if (push) begin
                inAck <= 1'b1;
                wrPtr <= nextPtr(wrPtr);
            end else if (inAck && !inReq) begin
                inAck <= 1'b0;
            end

            // Read side waits for previous ack to drop
            if (pop) begin
                outReq <= 1'b0;
                rdPtr  <= nextPtr(rdPtr);
            end else if (!outReq && !outAck && fill != '0) begin
                outReq <= 1'b1;
            end

            // Occupancy
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

endmodule

// File: design/cmdIssuer.sv
`timescale 1ns/1ps

module cmdIssuer (
    input  logic              clk,
    input  logic              en,
    // Host command port
    input  logic              cmdReq,
    output logic              cmdAck,
    input  logic [5:0]        cmdIndex,
    input  logic [31:0]       cmdArg,
    // Toward command queue
    output logic              frameReq,
    input  logic              frameAck,
    output sdCmdPkg::cmdFrame frame
);

    typedef enum logic [1:0] {
        sIdle,
        sPush,
        sHold,
        sDrain
    } issuerState;

    issuerState state;

    // ==============================
    // Handshake FSM
    // ==============================
    always_ff @(posedge clk or negedge en) begin
        if (!en) begin
            state    <= sIdle;
            frameReq <= 1'b0;
            cmdAck   <= 1'b0;
        end else begin
            case (state)
                // New host command
                sIdle: if (cmdReq) begin
                    frameReq <= 1'b1;
                    state    <= sPush;
                end
                // Frame accepted by queue so ack host
                sPush: if (frameAck) begin
                    frameReq <= 1'b0;
                    cmdAck   <= 1'b1;
                    state    <= sHold;
                end
                // Host releases
                sHold: if (!cmdReq) begin
                    cmdAck <= 1'b0;
                    state  <= sDrain;
                end
                // Queue side must finish its four phases too
                sDrain: if (!frameAck) begin
                    state <= sIdle;
                end
                default: state <= sIdle;
            endcase
        end
    end

    // Latch host data as request is seen
    always_ff @(posedge clk) begin
        if (state == sIdle && cmdReq) begin
            frame.index    <= cmdIndex;
            frame.arg      <= cmdArg;
            frame.needResp <= sdCmdPkg::expectsResp(cmdIndex);
        end
    end

endmodule

// File: design/crc7.sv
`timescale 1ns/1ps

module crc7 (
    input  logic       clk,
    input  logic       en,
    input  logic       clear,
    input  logic       shift,
    input  logic       din,
    output logic [6:0] crc
);

    // Feedback term for x^7
    logic fb;

    assign fb = din ^ crc[6];

    // Polynomial x^7 + x^3 + 1
    always_ff @(posedge clk or negedge en) begin
        if (!en) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shift) begin
            // Taps at bit 3 and bit 0
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

endmodule

// File: design/sdCmdPkg.sv
package sdCmdPkg;

    // Command frame and short response length on the CMD line
    localparam int FrameBits = 48;

    // Command as queued between issuer and engine
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic        needResp;
    } cmdFrame;

    // Outcome of one command
    typedef enum logic [1:0] {
        statOk,
        statNoResp,
        statTimeout,
        statBadFrame
    } respStatus;

    // Result as queued toward the host
    // Index and argument stay zero without a response
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        respStatus   status;
    } respFrame;

    // Only CMD0 (GO_IDLE_STATE) goes without a response here
    function automatic logic expectsResp(input logic [5:0] index);
        return index != 6'd0;
    endfunction

endpackage
